// ==== compile.f ====
+incdir+src
+incdir+test
src/mapper_pkg.sv
src/cart_config_regs.sv
src/mapper_bank_regs.sv
src/vrc4_irq_timer.sv
src/address_translator.sv
src/coolgirl_cart.sv
test/tb_coolgirl_cart.sv

// ==== run.sh ====
#!/bin/sh
# Build the cartridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_coolgirl_cart -o sim_cart
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed"
	exit "$status"
fi

./obj_dir/sim_cart
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation reported failure"
	exit "$status"
fi

exit 0

// ==== test/cart_ref.svh ====
`ifndef CART_REF_SVH
`define CART_REF_SVH

// Expected A26-A13 for a ROM read with romsel low
function automatic logic [13:0] ref_prg(input logic [4:0] map, input logic [14:0] addr,
	input logic [12:0] base, input logic [4:0] mask, input logic [5:0] p0,
	input logic [5:0] p1, input logic pmode);
	logic [5:0] bank;    // A18-A13 before the mask
	logic [1:0] slot;    // 8 KB window inside $8000-$FFFF
	slot = addr[14:13];
	bank = {4'b1111, slot};                        // Last 32 KB unless remapped
	if (map == `MAP_MMC3)
	begin
		if (pmode && !slot[0])
			slot[1] = ~slot[1];                    // $8000 and $C000 trade places
		case (slot)
			2'd0:    bank = p0;                    // R6
			2'd1:    bank = p1;                    // R7
			2'd2:    bank = 6'b111110;
			default: bank = 6'b111111;
		endcase
	end
	else if (map == `MAP_AXROM)
		bank = {p0[3:0], slot};                    // One 32 KB bank
	else if (!slot[1])
	begin
		if (map == `MAP_VRC)
			bank = {1'b0, slot[0] ? p1[4:0] : p0[4:0]};
		else
			bank = {p0[4:0], slot[0]};             // UxROM 16 KB at $8000
	end
	return {base | {8'd0, bank[5:1] & ~mask}, bank[0]};
endfunction

// Expected A17-A10 for a PPU fetch
function automatic logic [7:0] ref_chr(input logic [4:0] map, input logic [13:0] pa,
	input logic [4:0] cmask, input logic [7:0][7:0] bk, input logic cmode, input logic half);
	logic [7:0] b;
	if (map == `MAP_MMC3)
	begin
		if (pa[12] == cmode)
			b = {bk[{2'b00, pa[11]}][7:1], pa[10]};   // R0/R1, 2 KB each
		else
			b = bk[3'd2 + {1'b0, pa[11:10]}];         // R2-R5, 1 KB each
	end
	else if (map == `MAP_VRC)
	begin
		b = bk[pa[12:10]];
		if (half)
			b = b >> 1;                                 // VRC2a drops the low line
	end
	else
		b = {bk[0][4:0], pa[12:10]};                    // 8 KB bank
	return {b[7:3] & ~cmask, b[2:0]};
endfunction

// Nametable page for the given mirroring
function automatic logic ref_ciram(input logic [1:0] mir, input logic [13:0] pa);
	logic a10;
	case (mir)
		2'b00:   a10 = pa[10];   // Vertical
		2'b01:   a10 = pa[11];   // Horizontal
		default: a10 = mir[0];   // One screen
	endcase
	return a10;
endfunction

// Edges from the control write to the IRQ, 114/114/113 per scanline
function automatic int ref_irq_edges(input logic [7:0] lat, input logic cyc);
	int steps;
	int edges;
	steps = 256 - int'(lat);
	edges = 0;
	for (int k = 0; k < steps; k++)
		edges += cyc ? 1 : ((k % 3 == 2) ? 113 : 114);
	return edges;
endfunction

`endif

// ==== test/tb_coolgirl_cart.sv ====
`default_nettype none

`include "mapper_params.svh"

module tb_coolgirl_cart;

	logic        m2 = 1'b0;
	logic        ppu_addr_in = 1'b1;   // Reset
	logic        romsel = 1'b1;
	logic        cpu_rw = 1'b1;
	logic [14:0] cpu_addr = '0;
	logic [7:0]  cpu_data = '0;
	logic        ppu_rd = 1'b0;
	logic        ppu_wr = 1'b1;
	logic [13:0] ppu_addr = '0;
	wire  [13:0] cpu_addr_out;
	wire         flash_we;
	wire         flash_oe;
	wire         sram_ce;
	wire         sram_we;
	wire         sram_oe;
	wire  [7:0]  ppu_addr_out;
	wire         ppu_rd_out;
	wire         ppu_wr_out;
	wire         ppu_ciram_a10;
	wire         irq;

	logic [12:0]     cfg_base;      // Model of the cartridge state
	logic [4:0]      cfg_mask;
	logic [4:0]      cfg_chr_mask;
	logic [1:0]      cfg_sram;
	logic [4:0]      cfg_map;
	logic [2:0]      cfg_flags;
	logic [1:0]      cfg_mir;
	logic            cfg_locked;
	logic            cfg_prg_we;
	logic            cfg_chr_we;
	logic            cfg_sram_en;
	logic [5:0]      bank_p0;
	logic [5:0]      bank_p1;
	logic [7:0][7:0] bank_chr;
	logic            mode_prg;
	logic            mode_chr;

	string       chk_name;
	logic        chk_cpu = 1'b0;
	logic        chk_ppu = 1'b0;
	logic        chk_strobe = 1'b0;
	logic        chk_sram = 1'b0;
	logic        sram_low_seen = 1'b0;  // SRAM selected during the high phase
	logic [13:0] exp_cpu;
	logic [7:0]  exp_ppu;
	logic        exp_a10;
	logic        exp_rd;
	logic        exp_wr;
	logic        exp_flash_we;
	logic        exp_flash_oe;
	logic        exp_sram_we;
	logic        exp_sram_oe;
	logic        exp_sram_low;

	`include "cart_ref.svh"

	coolgirl_cart dut0 (.*);

	always #2 m2 = ~m2;

	task automatic fail_value(input string name, input string sig, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("FAILED %s %s expected %0h actual %0h", name, sig, exp_val, act_val);
		$display("Test failed");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "stopping on timeout");
	endtask

	task automatic next_cycle();
		@(posedge m2);
		#1;                              // Drive just after the edge
	endtask

	task automatic apply_reset();
		ppu_addr_in = 1'b1;
		repeat (4) @(posedge m2);
		#1;
		ppu_addr_in  = 1'b0;
		cfg_base     = '0;
		cfg_mask     = '0;
		cfg_chr_mask = '0;
		cfg_sram     = '0;
		cfg_map      = '0;
		cfg_flags    = '0;
		cfg_mir      = 2'b00;
		cfg_locked   = 1'b0;
		cfg_prg_we   = 1'b0;
		cfg_chr_we   = 1'b0;
		cfg_sram_en  = 1'b0;
		mode_prg     = 1'b0;
		mode_chr     = 1'b0;
	endtask

	task automatic cpu_write(input logic rs, input logic [14:0] a, input logic [7:0] d);
		romsel   = rs;
		cpu_rw   = 1'b0;
		cpu_addr = a;
		cpu_data = d;
		next_cycle();
		romsel = 1'b1;                   // Bus idle
		cpu_rw = 1'b1;
	endtask

	task automatic cfg_write(input logic [2:0] idx, input logic [7:0] d);
		cpu_write(1'b1, {`CFG_WINDOW, 9'd0, idx}, d);
		if (!cfg_locked)
		begin
			case (idx)
				3'd0: cfg_base[12:8] = d[4:0];
				3'd1: cfg_base[7:0]  = d;
				3'd2: cfg_mask       = d[4:0];
				3'd4: cfg_chr_mask   = d[4:0];
				3'd5: cfg_sram       = d[1:0];
				3'd6: {cfg_flags, cfg_map} = d;
				3'd7:
				begin
					cfg_locked = d[7];
					cfg_mir    = d[4:3];
					{cfg_prg_we, cfg_chr_we, cfg_sram_en} = d[2:0];
				end
				default: ;
			endcase
		end
	endtask

	// VRC register write through a random pair of ORed address lines
	task automatic vrc_write(input logic [4:0] idx, input logic [7:0] d);
		logic [14:0] a;
		logic [2:0]  sh;
		logic [4:0]  slot;
		sh   = {2'($urandom), 1'b0};
		a    = {idx[4:2], 12'd0};
		slot = idx - 5'd12;
		if (cfg_flags[0])
			a = a | (15'(idx[0]) << (sh + 3'd1)) | (15'(idx[1]) << sh);   // Lines swapped
		else
			a = a | (15'(idx[1]) << (sh + 3'd1)) | (15'(idx[0]) << sh);
		cpu_write(1'b0, a, d);
		if (idx[4:2] == 3'b000)
			bank_p0 = {1'b0, d[4:0]};
		else if (idx[4:2] == 3'b001)
			cfg_mir = d[1:0];
		else if (idx[4:2] == 3'b010)
			bank_p1 = {1'b0, d[4:0]};
		else if ((idx >= 5'd12) && (idx <= 5'd27))
		begin
			if (slot[0])
				bank_chr[slot[3:1]][7:4] = d[3:0];
			else
				bank_chr[slot[3:1]][3:0] = d[3:0];
		end
	endtask

	task automatic probe_cpu(input string name, input logic rs, input logic [14:0] a);
		romsel       = rs;
		cpu_addr     = a;
		exp_cpu      = rs ? {12'd0, cfg_sram} :
			ref_prg(cfg_map, a, cfg_base, cfg_mask, bank_p0, bank_p1, mode_prg);
		exp_flash_oe = rs;               // Flash drives the bus on ROM reads only
		exp_sram_we  = 1'b1;             // No write on a read cycle
		exp_sram_oe  = 1'b0;
		chk_name     = name;
		chk_cpu      = 1'b1;
		next_cycle();
		chk_cpu = 1'b0;
		romsel  = 1'b1;
	endtask

	// SRAM select needs m2 high, one probe cycle then one idle cycle
	task automatic probe_sram(input string name, input logic [14:0] a);
		sram_low_seen = 1'b0;
		romsel        = 1'b1;
		cpu_addr      = a;
		exp_sram_low  = (a[14:13] == 2'b11) && cfg_sram_en;   // $6000-$7FFF
		chk_name      = name;
		chk_sram      = 1'b1;
		next_cycle();
		chk_sram = 1'b0;
		cpu_addr = '0;
		next_cycle();
	endtask

	task automatic probe_ppu(input string name, input logic [13:0] pa);
		ppu_addr = pa;
		exp_ppu  = ref_chr(cfg_map, pa, cfg_chr_mask, bank_chr, mode_chr, cfg_flags[1]);
		exp_a10  = ref_ciram(cfg_mir, pa);
		exp_rd   = pa[13];               // ppu_rd held low
		exp_wr   = !(!ppu_wr && !pa[13] && cfg_chr_we);   // CHR RAM write in pattern space
		chk_name = name;
		chk_ppu  = 1'b1;
		next_cycle();
		chk_ppu = 1'b0;
	endtask

	task automatic probe_ppu_write(input string name, input logic [13:0] pa);
		ppu_wr = 1'b0;
		probe_ppu(name, pa);
		ppu_wr = 1'b1;
	endtask

	task automatic wait_irq_low(input string name, input int expected);
		int n;
		n = 0;
		while (irq && (n < 600))
		begin
			next_cycle();
			n++;
		end
		if (irq)
			fail_plain("irq did not go low within 600 cycles");
		else
			assert (n == expected) else fail_value(name, "edges", 32'(expected), 32'(n));
	endtask

	always @(sram_ce)
	begin
		if (!sram_ce)
			sram_low_seen = 1'b1;
	end

	// Compare at the falling edge, half a cycle away from any input change
	always @(negedge m2)
	begin
		if (chk_cpu)
		begin
			assert (cpu_addr_out === exp_cpu)
			else fail_value(chk_name, "cpu_addr_out", 32'(exp_cpu), 32'(cpu_addr_out));
			assert (flash_oe === exp_flash_oe)
			else fail_value(chk_name, "flash_oe", 32'(exp_flash_oe), 32'(flash_oe));
			assert (sram_we === exp_sram_we)
			else fail_value(chk_name, "sram_we", 32'(exp_sram_we), 32'(sram_we));
			assert (sram_oe === exp_sram_oe)
			else fail_value(chk_name, "sram_oe", 32'(exp_sram_oe), 32'(sram_oe));
		end
		if (chk_ppu)
		begin
			assert (ppu_addr_out === exp_ppu)
			else fail_value(chk_name, "ppu_addr_out", 32'(exp_ppu), 32'(ppu_addr_out));
			assert (ppu_ciram_a10 === exp_a10)
			else fail_value(chk_name, "ppu_ciram_a10", 32'(exp_a10), 32'(ppu_ciram_a10));
			assert (ppu_rd_out === exp_rd)
			else fail_value(chk_name, "ppu_rd_out", 32'(exp_rd), 32'(ppu_rd_out));
			assert (ppu_wr_out === exp_wr)
			else fail_value(chk_name, "ppu_wr_out", 32'(exp_wr), 32'(ppu_wr_out));
		end
		if (chk_strobe)
		begin
			assert (flash_we === exp_flash_we)
			else fail_value(chk_name, "flash_we", 32'(exp_flash_we), 32'(flash_we));
			assert (flash_oe === exp_flash_oe)
			else fail_value(chk_name, "flash_oe", 32'(exp_flash_oe), 32'(flash_oe));
			assert (sram_we === exp_sram_we)
			else fail_value(chk_name, "sram_we", 32'(exp_sram_we), 32'(sram_we));
			assert (sram_oe === exp_sram_oe)
			else fail_value(chk_name, "sram_oe", 32'(exp_sram_oe), 32'(sram_oe));
		end
		if (chk_sram)
			assert (sram_low_seen === exp_sram_low)
			else fail_value(chk_name, "sram_ce low", 32'(exp_sram_low), 32'(sram_low_seen));
	end

	initial
	begin
		logic [7:0] d;
		logic [7:0] lat;
		void'($urandom(84182));
		exp_cpu      = '0;
		exp_ppu      = '0;
		exp_a10      = 1'b0;
		exp_rd       = 1'b0;
		exp_wr       = 1'b1;
		exp_flash_we = 1'b1;
		exp_flash_oe = 1'b1;
		exp_sram_we  = 1'b1;
		exp_sram_oe  = 1'b0;
		exp_sram_low = 1'b0;
		apply_reset();

		cfg_write(3'd0, 8'($urandom));   // Config registers with UxROM
		cfg_write(3'd1, 8'($urandom));
		cfg_write(3'd2, 8'($urandom));
		cfg_write(3'd4, 8'($urandom));
		cfg_write(3'd5, 8'($urandom));
		cfg_write(3'd6, {3'b000, `MAP_UXROM});
		d = 8'($urandom);
		cpu_write(1'b0, 15'($urandom), d);
		bank_p0 = d[5:0];
		for (int k = 0; k < 2; k++)
		begin
			repeat (4) probe_cpu("uxrom $8000", 1'b0, {1'b0, 14'($urandom)});
			repeat (4) probe_cpu("uxrom $C000", 1'b0, {1'b1, 14'($urandom)});
			probe_cpu("sram page", 1'b1, {2'b11, 13'($urandom)});
			if (k == 0)
			begin
				cfg_write(3'd7, 8'h80);  // Lockout, later writes are ignored
				cfg_write(3'd0, 8'($urandom));
				cfg_write(3'd1, 8'($urandom));
				cfg_write(3'd2, 8'($urandom));
				cfg_write(3'd5, 8'($urandom));
				cfg_write(3'd6, {3'b000, `MAP_CNROM});
			end
		end
		apply_reset();

		cfg_write(3'd4, 8'($urandom));   // CNROM
		cfg_write(3'd6, {3'b000, `MAP_CNROM});
		repeat (4)
		begin
			d = 8'($urandom);
			cpu_write(1'b0, 15'($urandom), d);
			bank_chr[0] = d;
			repeat (4) probe_ppu("cnrom chr", 14'($urandom));
		end
		cfg_write(3'd6, {3'b000, `MAP_AXROM});
		for (int k = 0; k < 4; k++)
		begin
			d    = 8'($urandom);
			d[4] = k[0];                 // Alternate the screen page
			cpu_write(1'b0, 15'($urandom), d);
			bank_p0 = {1'b0, d[4:0]};
			cfg_mir = {1'b1, d[4]};
			repeat (4) probe_cpu("axrom prg", 1'b0, 15'($urandom));
			repeat (4) probe_ppu("axrom chr", 14'($urandom));
		end

		cfg_write(3'd6, {3'b000, `MAP_MMC3});
		for (int k = 0; k < 8; k++)
		begin
			d = 8'($urandom);
			cpu_write(1'b0, 15'h0000, {5'd0, 3'(k)});   // Bank select
			cpu_write(1'b0, 15'h0001, d);
			if (k < 6)
				bank_chr[3'(k)] = d;
			else if (k == 6)
				bank_p0 = d[5:0];
			else
				bank_p1 = d[5:0];
		end
		for (int k = 0; k < 4; k++)
		begin
			mode_prg = k[0];
			mode_chr = k[1];
			cpu_write(1'b0, 15'h0000, {mode_chr, mode_prg, 6'd0});
			repeat (8) probe_cpu("mmc3 prg", 1'b0, 15'($urandom));
			repeat (8) probe_ppu("mmc3 chr", 14'($urandom));
		end
		for (int k = 0; k < 2; k++)
		begin
			cpu_write(1'b0, 15'h2000, 8'(k));           // $A000 mirroring
			cfg_mir = 2'(k);
			repeat (4) probe_ppu("mmc3 mirroring", 14'($urandom));
		end

		for (int k = 0; k < 4; k++)
		begin
			cfg_write(3'd6, {1'b0, 2'(k), `MAP_VRC});   // Swap and half-bank flags
			vrc_write(5'b00000, 8'($urandom));
			vrc_write(5'b01000, 8'($urandom));
			for (int j = 12; j < 28; j++)
				vrc_write(5'(j), 8'($urandom));
			repeat (8) probe_cpu("vrc prg", 1'b0, 15'($urandom));
			for (int j = 0; j < 4; j++)
			begin
				vrc_write({3'b001, 2'($urandom)}, {6'($urandom), 2'(j)});
				repeat (4) probe_ppu("vrc chr", 14'($urandom));
			end
		end

		lat = 8'($urandom);              // Cycle mode IRQ
		vrc_write(`VRC_IRQ_LATCH_LO, {4'd0, lat[3:0]});
		vrc_write(`VRC_IRQ_LATCH_HI, {4'd0, lat[7:4]});
		vrc_write(`VRC_IRQ_CTRL, 8'h06);
		wait_irq_low("irq cycle mode", ref_irq_edges(lat, 1'b1));
		vrc_write(`VRC_IRQ_ACK, 8'h00);
		assert (irq === 1'b1) else fail_value("irq cycle ack", "irq", 32'd1, 32'(irq));

		vrc_write(`VRC_IRQ_LATCH_LO, 8'h0F);   // Scanline mode IRQ
		vrc_write(`VRC_IRQ_LATCH_HI, 8'h0F);
		vrc_write(`VRC_IRQ_CTRL, 8'h02);
		wait_irq_low("irq scanline mode", ref_irq_edges(8'hFF, 1'b0));
		vrc_write(`VRC_IRQ_ACK, 8'h00);
		assert (irq === 1'b1) else fail_value("irq scanline ack", "irq", 32'd1, 32'(irq));

		chk_name     = "flash_we locked";
		exp_flash_we = !cfg_prg_we;
		exp_flash_oe = 1'b1;             // CPU write cycle
		exp_sram_we  = 1'b0;
		exp_sram_oe  = 1'b1;
		chk_strobe   = 1'b1;
		cpu_write(1'b0, 15'h7000, 8'h00);
		chk_strobe = 1'b0;
		cfg_write(3'd7, 8'h04);          // PRG write enable
		chk_name     = "flash_we open";
		exp_flash_we = !cfg_prg_we;
		chk_strobe   = 1'b1;
		cpu_write(1'b0, 15'h7000, 8'h00);
		chk_strobe = 1'b0;
		probe_sram("sram disabled", {2'b11, 13'($urandom)});
		cfg_write(3'd7, 8'h03);          // CHR write and SRAM enables
		for (int k = 0; k < 4; k++)
			probe_sram("sram select", {2'(k), 13'($urandom)});
		repeat (8) probe_ppu_write("chr write", 14'($urandom));
		repeat (8) probe_ppu("nametable read", {1'b1, 13'($urandom)});

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/coolgirl_cart.sv ====
`default_nettype none

`include "mapper_params.svh"

module coolgirl_cart
	import mapper_pkg::*;
(
	input  wire         m2,
	input  wire         ppu_addr_in,     // Reset, active high
	input  wire         romsel,
	input  wire         cpu_rw,
	input  wire  [14:0] cpu_addr,
	input  wire  [7:0]  cpu_data,
	input  wire         ppu_rd,
	input  wire         ppu_wr,
	input  wire  [13:0] ppu_addr,
	output wire  [13:0] cpu_addr_out,    // A26-A13
	output wire         flash_we,
	output wire         flash_oe,
	output wire         sram_ce,
	output wire         sram_we,
	output wire         sram_oe,
	output wire  [7:0]  ppu_addr_out,    // A17-A10
	output wire         ppu_rd_out,
	output wire         ppu_wr_out,
	output wire         ppu_ciram_a10,
	output wire         irq              // Active low
);

	wire [`CPU_BASE_W-1:0] cpu_base;
	wire [`CPU_MASK_W-1:0] cpu_mask;
	wire [`CHR_MASK_W-1:0] chr_mask;
	wire [1:0]             sram_page;
	wire mapper_code_t     mapper;
	wire [2:0]             flags;
	wire                   sram_enabled;
	wire                   prg_write_enabled;
	wire                   chr_write_enabled;
	wire mirroring_e       mirroring;
	wire                   mir_wr;
	wire mirroring_e       mir_val;
	wire chr_bank_u [7:0]  chr_bank;
	wire [`PRG_MAP_W-1:0]  prg_bank0;
	wire [`PRG_MAP_W-1:0]  prg_bank1;
	wire                   mmc3_prg_mode;
	wire                   mmc3_chr_mode;

	cart_config_regs cfg0 (
		.m2, .ppu_addr_in, .romsel, .cpu_rw, .cpu_addr, .cpu_data, .mir_wr, .mir_val,
		.cpu_base, .cpu_mask, .chr_mask, .sram_page, .mapper, .flags,
		.sram_enabled, .prg_write_enabled, .chr_write_enabled, .mirroring
	);

	mapper_bank_regs banks0 (
		.m2, .ppu_addr_in, .romsel, .cpu_rw, .cpu_addr, .cpu_data, .mapper, .flags,
		.chr_bank, .prg_bank0, .prg_bank1, .mmc3_prg_mode, .mmc3_chr_mode,
		.mir_wr, .mir_val
	);

	vrc4_irq_timer irq0 (
		.m2, .ppu_addr_in, .romsel, .cpu_rw, .cpu_addr, .cpu_data, .mapper, .flags,
		.irq_n (irq)
	);

	address_translator xlat0 (
		.m2, .romsel, .cpu_rw, .cpu_addr, .ppu_rd, .ppu_wr, .ppu_addr,
		.cpu_base, .cpu_mask, .chr_mask, .sram_page, .mapper, .flags,
		.sram_enabled, .prg_write_enabled, .chr_write_enabled, .mirroring,
		.chr_bank, .prg_bank0, .prg_bank1, .mmc3_prg_mode, .mmc3_chr_mode,
		.cpu_addr_out, .flash_we, .flash_oe, .sram_ce, .sram_we, .sram_oe,
		.ppu_addr_out, .ppu_rd_out, .ppu_wr_out, .ppu_ciram_a10
	);

endmodule

`default_nettype wire

// ==== src/address_translator.sv ====
`default_nettype none

`include "mapper_params.svh"

module address_translator
	import mapper_pkg::*;
(
	input  wire                    m2,
	input  wire                    romsel,
	input  wire                    cpu_rw,
	input  wire  [14:0]            cpu_addr,
	input  wire                    ppu_rd,
	input  wire                    ppu_wr,
	input  wire  [13:0]            ppu_addr,
	input  wire  [`CPU_BASE_W-1:0] cpu_base,
	input  wire  [`CPU_MASK_W-1:0] cpu_mask,
	input  wire  [`CHR_MASK_W-1:0] chr_mask,
	input  wire  [1:0]             sram_page,
	input  wire  mapper_code_t     mapper,
	input  wire  [2:0]             flags,
	input  wire                    sram_enabled,
	input  wire                    prg_write_enabled,
	input  wire                    chr_write_enabled,
	input  wire  mirroring_e       mirroring,
	input  wire  chr_bank_u [7:0]  chr_bank,
	input  wire  [`PRG_MAP_W-1:0]  prg_bank0,
	input  wire  [`PRG_MAP_W-1:0]  prg_bank1,
	input  wire                    mmc3_prg_mode,
	input  wire                    mmc3_chr_mode,
	output logic [13:0]            cpu_addr_out,   // A26-A13
	output logic                   flash_we,
	output logic                   flash_oe,
	output logic                   sram_ce,
	output logic                   sram_we,
	output logic                   sram_oe,
	output logic [7:0]             ppu_addr_out,   // A17-A10
	output logic                   ppu_rd_out,
	output logic                   ppu_wr_out,
	output logic                   ppu_ciram_a10
);

	logic [`PRG_MAP_W-1:0] prg_map;   // Mapped A18-A13
	logic [`CHR_MAP_W-1:0] chr_map;   // Mapped A17-A10
	chr_bank_u             chr_sel;   // 1 KB bank under the current PPU fetch

	assign chr_sel = chr_bank[ppu_addr[12:10]];

	always_comb
	begin
		prg_map = {4'b1111, cpu_addr[14:13]};          // Last 32 KB
		chr_map = {5'b00000, ppu_addr[12:10]};
		if (!mapper[4])                               // Simple mappers
		begin
			if (!mapper[3])
				prg_map = {cpu_addr[14] ? `PRG_LAST_16K : prg_bank0[4:0], cpu_addr[13]};
			else
				prg_map = {prg_bank0[3:0], cpu_addr[14:13]}; // 32 KB, AxROM
			chr_map = {chr_bank[0].num[4:0], ppu_addr[12:10]};
		end
		else if (mapper == `MAP_MMC3)
		begin
			case ({cpu_addr[14:13], mmc3_prg_mode})
				3'b000, 3'b101: prg_map = prg_bank0;          // R6
				3'b001, 3'b100: prg_map = `MMC3_SECOND_LAST;
				3'b010, 3'b011: prg_map = prg_bank1;          // R7 at $A000
				default:        prg_map = `MMC3_LAST;
			endcase
			if (ppu_addr[12] == mmc3_chr_mode)
				chr_map = {chr_bank[{2'b00, ppu_addr[11]}].num[7:1], ppu_addr[10]}; // 2 KB
			else
				chr_map = chr_bank[{1'b0, ppu_addr[11:10]} + 3'd2].num;           // 1 KB
		end
		else if (mapper == `MAP_VRC)
		begin
			if (cpu_addr[14])
				prg_map = {`PRG_LAST_16K, cpu_addr[13]};
			else
				prg_map = {1'b0, cpu_addr[13] ? prg_bank1[4:0] : prg_bank0[4:0]};
			chr_map = flags[1] ? {1'b0, chr_sel.num[7:1]} : chr_sel.num;       // VRC2a halves
		end
	end

	always_comb
	begin
		case (mirroring)
			MIR_VERTICAL:   ppu_ciram_a10 = ppu_addr[10];
			MIR_HORIZONTAL: ppu_ciram_a10 = ppu_addr[11];
			default:        ppu_ciram_a10 = mirroring[0];  // Single screen A or B
		endcase
	end

	assign cpu_addr_out = !romsel ?
		{cpu_base | {{(`CPU_BASE_W - `CPU_MASK_W){1'b0}}, prg_map[5:1] & ~cpu_mask}, prg_map[0]} :
		{12'd0, sram_page};                             // SRAM window
	assign ppu_addr_out = {chr_map[7:3] & ~chr_mask, chr_map[2:0]};

	assign flash_we   = cpu_rw | romsel | ~prg_write_enabled;
	assign flash_oe   = ~cpu_rw | romsel;
	assign sram_ce    = ~(cpu_addr[14] & cpu_addr[13] & m2 & romsel & sram_enabled); // $6000
	assign sram_we    = cpu_rw;
	assign sram_oe    = ~cpu_rw;
	assign ppu_rd_out = ppu_rd | ppu_addr[13];         // Nametables stay in CIRAM
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~chr_write_enabled;

endmodule

`default_nettype wire

// ==== src/vrc4_irq_timer.sv ====
`default_nettype none

`include "mapper_params.svh"

module vrc4_irq_timer
	import mapper_pkg::*;
(
	input  wire                m2,
	input  wire                ppu_addr_in,   // Reset, active high
	input  wire                romsel,
	input  wire                cpu_rw,
	input  wire  [14:0]        cpu_addr,
	input  wire  [7:0]         cpu_data,
	input  wire  mapper_code_t mapper,
	input  wire  [2:0]         flags,
	output logic               irq_n
);

	logic [7:0] latch;        // Reload value L
	logic [7:0] counter;
	logic       irq_mode;     // M, 1 counts CPU cycles
	logic       irq_en;       // E
	logic       irq_en_ack;   // A, copied to E on acknowledge
	logic [6:0] presc;
	logic [1:0] phase;        // Scanline 0, 1, 2 of the 114/114/113 pattern
	logic [6:0] presc_nxt;
	logic       presc_tick;   // One scanline elapsed
	logic       step;         // Counter advances at this edge
	logic       vrc_wr;
	logic [4:0] vrc_idx;

	assign vrc_wr     = !cpu_rw && !romsel && (mapper == `MAP_VRC);
	assign vrc_idx    = vrc_index(cpu_addr, flags[0]);
	assign presc_nxt  = presc + 7'd1;
	assign presc_tick = presc_nxt == (phase[1] ? `VRC_PRESC_SHORT : `VRC_PRESC_LONG);
	assign step       = irq_mode || presc_tick;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			latch      <= 8'd0;
			counter    <= 8'd0;
			irq_mode   <= 1'b0;
			irq_en     <= 1'b0;
			irq_en_ack <= 1'b0;
			presc      <= 7'd0;
			phase      <= 2'd0;
			irq_n      <= 1'b1;
		end
		else
		begin
			if (vrc_wr && (vrc_idx == `VRC_IRQ_LATCH_LO))
				latch[3:0] <= cpu_data[3:0];
			if (vrc_wr && (vrc_idx == `VRC_IRQ_LATCH_HI))
				latch[7:4] <= cpu_data[3:0];

			if (vrc_wr && (vrc_idx == `VRC_IRQ_CTRL))
			begin
				irq_n <= 1'b1;                                     // Control also acks
				{irq_mode, irq_en, irq_en_ack} <= cpu_data[2:0];
				if (cpu_data[1])
				begin
					counter <= latch;                              // Restart from L
					presc   <= 7'd0;
					phase   <= 2'd0;
				end
			end
			else if (vrc_wr && (vrc_idx == `VRC_IRQ_ACK))
			begin
				irq_n  <= 1'b1;
				irq_en <= irq_en_ack;
			end
			else if ((mapper == `MAP_VRC) && irq_en)
			begin
				if (!irq_mode)
				begin
					presc <= presc_tick ? 7'd0 : presc_nxt;
					if (presc_tick)
						phase <= phase[1] ? 2'd0 : phase + 2'd1;
				end
				if (step)
				begin
					if (counter == 8'hFF)
					begin
						irq_n   <= 1'b0;                           // Overflow
						counter <= latch;
					end
					else
						counter <= counter + 8'd1;
				end
			end
		end
	end

	// Scanline prescaler stays within one long scanline
	a_presc_bound: assert property (
		@(posedge m2) disable iff (ppu_addr_in)
		presc <= `VRC_PRESC_LONG
	);

endmodule

`default_nettype wire

// ==== src/mapper_bank_regs.sv ====
`default_nettype none

`include "mapper_params.svh"

module mapper_bank_regs
	import mapper_pkg::*;
(
	input  wire                      m2,
	input  wire                      ppu_addr_in,     // Reset, active high
	input  wire                      romsel,
	input  wire                      cpu_rw,
	input  wire  [14:0]              cpu_addr,
	input  wire  [7:0]               cpu_data,
	input  wire  mapper_code_t       mapper,
	input  wire  [2:0]               flags,
	output chr_bank_u [7:0]          chr_bank,        // R0-R7 style CHR banks
	output logic [`PRG_MAP_W-1:0]    prg_bank0,
	output logic [`PRG_MAP_W-1:0]    prg_bank1,
	output logic                     mmc3_prg_mode,   // Swaps $8000 and $C000
	output logic                     mmc3_chr_mode,   // Swaps CHR halves
	output logic                     mir_wr,
	output mirroring_e               mir_val
);

	logic       rom_wr;        // CPU write to $8000-$FFFF
	logic [2:0] bank_sel;      // MMC3 bank select
	logic [4:0] vrc_idx;
	logic [4:0] vrc_chr;       // CHR nibble slot, $B000 is slot 0
	logic       vrc_chr_hit;

	assign rom_wr      = !cpu_rw && !romsel;
	assign vrc_idx     = vrc_index(cpu_addr, flags[0]);
	assign vrc_chr     = vrc_idx - 5'd12;
	assign vrc_chr_hit = (vrc_idx >= 5'd12) && (vrc_idx <= 5'd27);

	// Mirroring lives in the config bank, hand it the write
	always_comb
	begin
		mir_wr  = 1'b0;
		mir_val = MIR_VERTICAL;
		if (rom_wr)
		begin
			case (mapper)
				`MAP_AXROM:
				begin
					mir_wr  = 1'b1;
					mir_val = mirroring_e'({1'b1, cpu_data[4]});       // Single screen
				end
				`MAP_MMC3:
				begin
					mir_wr  = (cpu_addr[14:13] == 2'b01) && !cpu_addr[0]; // $A000 even
					mir_val = mirroring_e'({1'b0, cpu_data[0]});
				end
				`MAP_VRC:
				begin
					mir_wr  = (vrc_idx[4:2] == 3'b001);                 // $9000 group
					mir_val = mirroring_e'(cpu_data[1:0]);
				end
				default: ;
			endcase
		end
	end

	// MMC3 bank select and modes
	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			bank_sel      <= 3'd0;
			mmc3_prg_mode <= 1'b0;
			mmc3_chr_mode <= 1'b0;
		end
		else if (rom_wr && (mapper == `MAP_MMC3) && (cpu_addr[14:13] == 2'b00) && !cpu_addr[0])
		begin
			mmc3_chr_mode <= cpu_data[7];
			mmc3_prg_mode <= cpu_data[6];
			bank_sel      <= cpu_data[2:0];
		end
	end

	// Bank numbers
	always_ff @(posedge m2)
	begin
		if (rom_wr)
		begin
			case (mapper)
				`MAP_UXROM: prg_bank0       <= cpu_data[5:0];
				`MAP_CNROM: chr_bank[0].num <= cpu_data;           // 8 KB CHR
				`MAP_AXROM: prg_bank0       <= {1'b0, cpu_data[4:0]};
				`MAP_MMC3:
				begin
					if ((cpu_addr[14:13] == 2'b00) && cpu_addr[0])  // $8001 odd
					begin
						case (bank_sel)
							3'd6:    prg_bank0              <= cpu_data[5:0];
							3'd7:    prg_bank1              <= cpu_data[5:0];
							default: chr_bank[bank_sel].num <= cpu_data; // R0-R5
						endcase
					end
				end
				`MAP_VRC:
				begin
					if (vrc_idx[4:2] == 3'b000)
						prg_bank0 <= {1'b0, cpu_data[4:0]};            // $8000 group
					if (vrc_idx[4:2] == 3'b010)
						prg_bank1 <= {1'b0, cpu_data[4:0]};            // $A000 group
					if (vrc_chr_hit)
					begin
						if (vrc_chr[0])
							chr_bank[vrc_chr[3:1]].nib.hi <= cpu_data[3:0];
						else
							chr_bank[vrc_chr[3:1]].nib.lo <= cpu_data[3:0];
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/cart_config_regs.sv ====
`default_nettype none

`include "mapper_params.svh"

module cart_config_regs
	import mapper_pkg::*;
(
	input  wire                       m2,
	input  wire                       ppu_addr_in,      // Reset, active high
	input  wire                       romsel,
	input  wire                       cpu_rw,
	input  wire  [14:0]               cpu_addr,
	input  wire  [7:0]                cpu_data,
	input  wire                       mir_wr,           // Mirroring write from mapper logic
	input  wire  mirroring_e          mir_val,
	output logic [`CPU_BASE_W-1:0]    cpu_base,         // A26-A14
	output logic [`CPU_MASK_W-1:0]    cpu_mask,         // A18-A14
	output logic [`CHR_MASK_W-1:0]    chr_mask,         // A17-A13
	output logic [1:0]                sram_page,
	output mapper_code_t              mapper,
	output logic [2:0]                flags,
	output logic                      sram_enabled,
	output logic                      prg_write_enabled,
	output logic                      chr_write_enabled,
	output mirroring_e                mirroring
);

	logic                  lockout;  // Freezes the $5xxx slots
	logic                  cfg_wr;   // Write to an open config slot
	logic [`CFG_IDX_W-1:0] cfg_idx;

	assign cfg_idx = cpu_addr[`CFG_IDX_W-1:0];
	assign cfg_wr  = !cpu_rw && romsel && (cpu_addr[14:12] == `CFG_WINDOW) && !lockout;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cpu_base          <= '0;
			cpu_mask          <= '0;
			chr_mask          <= '0;
			sram_page         <= '0;
			mapper            <= '0;   // NROM
			flags             <= '0;
			sram_enabled      <= 1'b0;
			prg_write_enabled <= 1'b0;
			chr_write_enabled <= 1'b0;
			mirroring         <= MIR_VERTICAL;
			lockout           <= 1'b0;
		end
		else if (cfg_wr)
		begin
			case (cfg_idx)
				`CFG_BASE_HI:  cpu_base[12:8]   <= cpu_data[4:0];
				`CFG_BASE_LO:  cpu_base[7:0]    <= cpu_data;
				`CFG_MASK:     cpu_mask         <= cpu_data[4:0];
				`CFG_CHR_MASK: chr_mask         <= cpu_data[4:0];
				`CFG_SRAM:     sram_page        <= cpu_data[1:0];
				`CFG_MAPPER:   {flags, mapper}  <= cpu_data;
				`CFG_MISC:
				begin
					lockout   <= cpu_data[7];                   // Sticky until reset
					mirroring <= mirroring_e'(cpu_data[4:3]);
					{prg_write_enabled, chr_write_enabled, sram_enabled} <= cpu_data[2:0];
				end
				default: ;                                      // Slot 3 unused
			endcase
		end
		else if (mir_wr)
			mirroring <= mir_val;                               // Mapper owned update
	end

	// A locked cartridge keeps its mapper no matter what the CPU writes
	a_lockout_holds_mapper: assert property (
		@(posedge m2) disable iff (ppu_addr_in)
		lockout |=> $stable(mapper)
	);

endmodule

`default_nettype wire

// ==== src/mapper_pkg.sv ====
`default_nettype none

package mapper_pkg;

	// Nametable arrangement, values match $5xx7 bits 4:3
	typedef enum logic [1:0] {
		MIR_VERTICAL   = 2'b00, // CIRAM A10 from PPU A10
		MIR_HORIZONTAL = 2'b01, // CIRAM A10 from PPU A11
		MIR_SINGLE_A   = 2'b10, // Always page A
		MIR_SINGLE_B   = 2'b11  // Always page B
	} mirroring_e;

	typedef logic [4:0] mapper_code_t; // Mapper number

	// CHR bank register, MMC3 loads it whole, VRC by nibble
	typedef union packed {
		logic [7:0] num; // Whole bank number
		struct packed {
			logic [3:0] hi; // VRC high nibble
			logic [3:0] lo; // VRC low nibble
		} nib;
	} chr_bank_u;

	// VRC register index from A14-A12 and the two ORed address lines.
	// Boards differ in which CPU lines reach the chip, so swap picks the order.
	function automatic logic [4:0] vrc_index(input logic [14:0] addr, input logic swap);
		logic line_hi;
		logic line_lo;
		line_hi = addr[1] | addr[3] | addr[5] | addr[7]; // Odd lines
		line_lo = addr[0] | addr[2] | addr[4] | addr[6]; // Even lines
		return swap ? {addr[14:12], line_lo, line_hi} : {addr[14:12], line_hi, line_lo};
	endfunction

endpackage

`default_nettype wire

// ==== src/mapper_params.svh ====
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// Mapper numbers, $5xx6 bits 4:0
`define MAP_UXROM         5'b00001
`define MAP_CNROM         5'b00010
`define MAP_AXROM         5'b01000
`define MAP_MMC3          5'b10100
`define MAP_VRC           5'b11000

// Config window $5000-$5FFF
`define CFG_WINDOW        3'b101
`define CFG_IDX_W         3
`define CFG_BASE_HI       3'd0      // A26-A22
`define CFG_BASE_LO       3'd1      // A21-A14
`define CFG_MASK          3'd2      // PRG mask A18-A14
`define CFG_CHR_MASK      3'd4      // CHR mask A17-A13
`define CFG_SRAM          3'd5      // SRAM page
`define CFG_MAPPER        3'd6      // Flags and mapper number
`define CFG_MISC          3'd7      // Lockout, mirroring, enables

// Field widths
`define CPU_BASE_W        13
`define CPU_MASK_W        5
`define CHR_MASK_W        5
`define PRG_MAP_W         6
`define CHR_MAP_W         8

// Fixed PRG banks
`define PRG_LAST_16K      5'b11111
`define MMC3_SECOND_LAST  6'b111110
`define MMC3_LAST         6'b111111

// VRC4 IRQ register indices and prescaler periods
`define VRC_IRQ_LATCH_LO  5'b11100
`define VRC_IRQ_LATCH_HI  5'b11101
`define VRC_IRQ_CTRL      5'b11110
`define VRC_IRQ_ACK       5'b11111
`define VRC_PRESC_LONG    7'd114
`define VRC_PRESC_SHORT   7'd113

`endif
